/* verilog/fetch_defs.svh */
// Shared constants for the RV32I fetch front end.
// Include wherever the reset PC, register map or bus byte order is needed.
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// PC loaded on reset
`define FETCH_RESET_PC 32'h0000_0100

// Instruction and address width
`define FETCH_WORD_W 32

// Configuration register map
`define FETCH_CFG_TRAP_VEC 2'd0
`define FETCH_CFG_CTRL     2'd1

// Bus byte order
// 1 uses bus data as it arrives, 0 swaps bytes into instruction order
`define FETCH_BUS_BIG_ENDIAN 1'b0

`endif

/* verilog/fetch_pkg.sv */
// Types shared by the fetch front end: words, opcodes, branch and jump
// fields and the fetch/decode pipeline register.
`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [`FETCH_WORD_W-1:0] word_t;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    // Conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_05;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm04_01;
        logic       imm11;
        opcode_t    opcode;
    } sbtype_t;

    // JAL layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_01;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } ujtype_t;

    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  prediction;
        word_t predicted_address;
        logic  mal_insn;
        logic  fault_insn;
        word_t fault_addr;
    } fetch_decode_t;

endpackage

/* verilog/fetch_config.sv */
// Configuration registers of the fetch front end.
// Holds the trap vector and the predictor enable behind a small register port.
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_config import fetch_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  word_t      cfg_wdata,
    output word_t      cfg_rdata,
    output word_t      trap_vector,
    output logic       pred_enable
);

    // Writes land on the next edge
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            trap_vector <= '0;
            pred_enable <= 1'b1;
        end else if (cfg_we) begin
            case (cfg_addr)
                `FETCH_CFG_TRAP_VEC: trap_vector <= cfg_wdata;
                `FETCH_CFG_CTRL:     pred_enable <= cfg_wdata[0];
                default: ;
            endcase
        end
    end

    // Readback, unmapped addresses and unused bits give zero
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            `FETCH_CFG_TRAP_VEC: cfg_rdata = trap_vector;
            `FETCH_CFG_CTRL:     cfg_rdata[0] = pred_enable;
            default: ;
        endcase
    end

endmodule

/* verilog/branch_predictor.sv */
// Static predictor for the fetched word.
// Backward branches and every JAL are taken; the target is pc plus the offset.
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
    input  word_t insn_word,
    input  word_t pc,
    input  logic  pred_enable,
    output logic  predict_taken,
    output word_t target_addr
);

    sbtype_t insn_sb;
    ujtype_t insn_uj;
    word_t   imm_sb;
    word_t   imm_uj;
    logic    is_branch;
    logic    is_jal;

    assign insn_sb = sbtype_t'(insn_word);
    assign insn_uj = ujtype_t'(insn_word);

    // Sign extended offsets, bit 0 always zero
    assign imm_sb = {{19{insn_sb.imm12}}, insn_sb.imm12, insn_sb.imm11,
                     insn_sb.imm10_05, insn_sb.imm04_01, 1'b0};
    assign imm_uj = {{11{insn_uj.imm20}}, insn_uj.imm20, insn_uj.imm19_12,
                     insn_uj.imm11, insn_uj.imm10_01, 1'b0};

    assign is_branch = (insn_sb.opcode == BRANCH);
    assign is_jal    = (insn_uj.opcode == JAL);

    // Sign bit of the branch offset marks a backward branch
    assign predict_taken = pred_enable && (is_jal || (is_branch && insn_sb.imm12));
    assign target_addr   = is_jal ? pc + imm_uj : pc + imm_sb;

endmodule

/* verilog/fetch_unit.sv */
// Instruction bus requester, one request outstanding at a time.
// Holds the returned word until the fetch stage accepts it.
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  word_t pc,
    input  logic  pc_redirect,
    input  logic  advance,
    output logic  ibus_req,
    output word_t ibus_addr,
    input  word_t ibus_rdata,
    input  logic  ibus_ready,
    input  logic  ibus_error,
    output logic  insn_ready,
    output word_t insn_word,
    output logic  insn_fault,
    output logic  mal_addr
);

    localparam bit BIG_ENDIAN = `FETCH_BUS_BIG_ENDIAN;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_HOLD
    } state_t;

    state_t state;
    state_t next_state;
    logic   stale;
    logic   held_err;
    word_t  req_addr;
    word_t  bus_word;

    assign bus_word = BIG_ENDIAN ? ibus_rdata
                    : {ibus_rdata[7:0], ibus_rdata[15:8],
                       ibus_rdata[23:16], ibus_rdata[31:24]};

    // Misaligned pc never reaches the bus
    assign mal_addr = (pc[1:0] != 2'b00);

    always_comb begin
        next_state = state;
        case (state)
            // A pc about to change is not worth requesting
            S_IDLE: if (!mal_addr && !pc_redirect) next_state = S_WAIT;
            S_WAIT: begin
                if (ibus_ready) begin
                    next_state = (stale || pc_redirect) ? S_IDLE : S_HOLD;
                end
            end
            S_HOLD: if (advance || pc_redirect) next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= S_IDLE;
            stale <= 1'b0;
        end else begin
            state <= next_state;
            if (state == S_IDLE) begin
                stale <= 1'b0;
            end else if (state == S_WAIT && pc_redirect && !ibus_ready) begin
                // Response still to come belongs to the old path
                stale <= 1'b1;
            end
        end
    end

    // Address and returned word
    always_ff @(posedge CLK) begin
        if (state == S_IDLE && next_state == S_WAIT) begin
            req_addr <= pc;
        end
        if (state == S_WAIT && next_state == S_HOLD) begin
            insn_word <= bus_word;
            held_err  <= ibus_error;
        end
    end

    assign ibus_req   = (state == S_WAIT);
    assign ibus_addr  = req_addr;
    assign insn_ready = (state == S_HOLD) && !held_err;
    assign insn_fault = (state == S_HOLD) && held_err;

endmodule

/* verilog/fetch_stage.sv */
// Program counter, next-PC choice and the fetch/decode pipeline register.
// Next PC priority is trap, redirect, prediction, then pc+4.
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          stall,
    input  logic          flush,
    input  logic          redirect,
    input  logic          trap,
    input  word_t         redirect_addr,
    input  word_t         trap_vector,
    input  logic          insn_ready,
    input  logic          insn_fault,
    input  logic          mal_addr,
    input  word_t         insn_word,
    input  logic          predict_taken,
    input  word_t         target_addr,
    output word_t         pc,
    output logic          pc_redirect,
    output logic          advance,
    output fetch_decode_t fd_reg
);

    word_t pc4;
    word_t npc;
    logic  take_pred;
    logic  squash;
    logic  pc_en;

    assign pc4 = pc + 32'd4;

    // Faults and misaligned pcs are accepted like instructions
    assign advance = (insn_ready || insn_fault || mal_addr) && !stall;

    // Prediction only counts for a real word
    assign take_pred = insn_ready && predict_taken;
    assign squash    = insn_fault || mal_addr;

    assign npc = trap      ? trap_vector
               : redirect  ? redirect_addr
               : take_pred ? target_addr
               : pc4;

    assign pc_redirect = trap || redirect || (advance && take_pred);
    assign pc_en       = trap || redirect || advance;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= `FETCH_RESET_PC;
        end else if (pc_en) begin
            pc <= npc;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fd_reg <= '0;
        end else if (!stall) begin
            // Flush, or a bubble when nothing was accepted
            if (flush || !advance) begin
                fd_reg <= '0;
            end else begin
                fd_reg.valid      <= 1'b1;
                fd_reg.instr      <= squash ? '0 : insn_word;
                fd_reg.pc         <= pc;
                fd_reg.pc4        <= pc4;
                fd_reg.prediction <= take_pred;
                // Where fetch went next on the predicted path
                fd_reg.predicted_address <= take_pred ? target_addr : pc4;
                fd_reg.mal_insn   <= mal_addr;
                fd_reg.fault_insn <= insn_fault;
                fd_reg.fault_addr <= pc;
            end
        end
    end

endmodule

/* verilog/fetch_top.sv */
// Fetch front end top level.
// Joins the configuration block, fetch stage, bus requester and predictor.
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          stall,
    input  logic          flush,
    input  logic          redirect,
    input  word_t         redirect_addr,
    input  logic          trap,
    input  logic          cfg_we,
    input  logic [1:0]    cfg_addr,
    input  word_t         cfg_wdata,
    output word_t         cfg_rdata,
    output logic          ibus_req,
    output word_t         ibus_addr,
    input  word_t         ibus_rdata,
    input  logic          ibus_ready,
    input  logic          ibus_error,
    output fetch_decode_t fd_reg
);

    word_t pc;
    word_t trap_vector;
    word_t insn_word;
    word_t target_addr;
    logic  pred_enable;
    logic  pc_redirect;
    logic  advance;
    logic  insn_ready;
    logic  insn_fault;
    logic  mal_addr;
    logic  predict_taken;

    fetch_config u_config (
        .CLK         (CLK),
        .nRST        (nRST),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .trap_vector (trap_vector),
        .pred_enable (pred_enable)
    );

    fetch_stage u_stage (
        .CLK           (CLK),
        .nRST          (nRST),
        .stall         (stall),
        .flush         (flush),
        .redirect      (redirect),
        .trap          (trap),
        .redirect_addr (redirect_addr),
        .trap_vector   (trap_vector),
        .insn_ready    (insn_ready),
        .insn_fault    (insn_fault),
        .mal_addr      (mal_addr),
        .insn_word     (insn_word),
        .predict_taken (predict_taken),
        .target_addr   (target_addr),
        .pc            (pc),
        .pc_redirect   (pc_redirect),
        .advance       (advance),
        .fd_reg        (fd_reg)
    );

    fetch_unit u_fetch (
        .CLK         (CLK),
        .nRST        (nRST),
        .pc          (pc),
        .pc_redirect (pc_redirect),
        .advance     (advance),
        .ibus_req    (ibus_req),
        .ibus_addr   (ibus_addr),
        .ibus_rdata  (ibus_rdata),
        .ibus_ready  (ibus_ready),
        .ibus_error  (ibus_error),
        .insn_ready  (insn_ready),
        .insn_word   (insn_word),
        .insn_fault  (insn_fault),
        .mal_addr    (mal_addr)
    );

    branch_predictor u_predict (
        .insn_word     (insn_word),
        .pc            (pc),
        .pred_enable   (pred_enable),
        .predict_taken (predict_taken),
        .target_addr   (target_addr)
    );

endmodule

/* verification/fetch_assert.sv */
// Bus protocol and pipeline register checks for the fetch front end.
// Bound into every fetch_top instance.
`timescale 1ns/1ps

module fetch_assert import fetch_pkg::*; (
    input logic          CLK,
    input logic          nRST,
    input logic          ibus_req,
    input logic          ibus_ready,
    input word_t         ibus_addr,
    input logic          stall,
    input logic          flush,
    input fetch_decode_t fd_reg
);

    // Address holds until the ready pulse
    a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        ibus_req && !ibus_ready |=> $stable(ibus_addr))
        else $error("ibus_addr changed while a request was pending");

    a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> $stable(fd_reg))
        else $error("fd_reg changed during stall");

    a_flush_clear: assert property (@(posedge CLK) disable iff (!nRST)
        flush && !stall |=> fd_reg == '0)
        else $error("fd_reg not cleared after flush");

endmodule

bind fetch_top fetch_assert u_assert (.*);

/* verification/fetch_tb.sv */
// Testbench for the fetch front end.
// Runs a table of pipeline and configuration actions against a random-latency bus model.
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb import fetch_pkg::*; ();

    typedef enum int {K_NONE, K_STALL, K_FLUSH, K_TVEC, K_PRED, K_REDIR, K_TRAP, K_MAL} kind_t;

    logic          CLK;
    logic          nRST;
    logic          stall;
    logic          flush;
    logic          redirect;
    logic          trap;
    logic          cfg_we;
    logic [1:0]    cfg_addr;
    word_t         redirect_addr;
    word_t         cfg_wdata;
    word_t         cfg_rdata;
    logic          ibus_req;
    word_t         ibus_addr;
    word_t         ibus_rdata;
    logic          ibus_ready;
    logic          ibus_error;
    fetch_decode_t fd_reg;

    word_t mem [0:255];
    word_t err_addr;
    word_t seed;
    word_t model_pc;
    word_t trap_vec_m;
    logic  pred_en_m;
    bit    mem_busy;
    int    mem_delay;
    int    pulses;
    int    errors;
    int    cycles;
    int    cycle_limit;

    kind_t row_kind[$];
    word_t row_arg[$];
    word_t row_arg2[$];
    word_t row_pc[$];

    fetch_top i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic word_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t swap_bytes(word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // BEQ x0, x0 and JAL x0 encoders
    function automatic word_t enc_branch(int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'd0, 5'd0, 3'b000, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic word_t enc_jal(int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
    endfunction

    // Reference model of one accepted fetch
    function automatic fetch_decode_t expect_fd(word_t p, logic mal);
        fetch_decode_t e;
        word_t w;
        word_t imm;
        logic taken;
        e = '0;
        imm = '0;
        taken = 1'b0;
        e.valid = 1'b1;
        e.pc = p;
        e.pc4 = p + 32'd4;
        e.fault_addr = p;
        e.predicted_address = p + 32'd4;
        if (mal) begin
            e.mal_insn = 1'b1;
        end else if (p == err_addr) begin
            e.fault_insn = 1'b1;
        end else begin
            w = mem[p[9:2]];
            e.instr = w;
            if (w[6:0] == 7'b1101111) begin
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                taken = 1'b1;
            end else if (w[6:0] == 7'b1100011) begin
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                taken = imm[31];
            end
            if (taken && pred_en_m) begin
                e.prediction = 1'b1;
                e.predicted_address = p + imm;
            end
        end
        return e;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_fd(fetch_decode_t got, fetch_decode_t exp);
        check_bit("fd_reg.valid", got.valid, exp.valid);
        check_word("fd_reg.instr", got.instr, exp.instr);
        check_word("fd_reg.pc", got.pc, exp.pc);
        check_word("fd_reg.pc4", got.pc4, exp.pc4);
        check_bit("fd_reg.prediction", got.prediction, exp.prediction);
        check_word("fd_reg.predicted_address", got.predicted_address, exp.predicted_address);
        check_bit("fd_reg.mal_insn", got.mal_insn, exp.mal_insn);
        check_bit("fd_reg.fault_insn", got.fault_insn, exp.fault_insn);
        check_word("fd_reg.fault_addr", got.fault_addr, exp.fault_addr);
    endtask

    task automatic put(word_t a, word_t w);
        mem[a[9:2]] = w;
    endtask

    task automatic add_row(kind_t k, word_t a, word_t a2, word_t p);
        row_kind.push_back(k);
        row_arg.push_back(a);
        row_arg2.push_back(a2);
        row_pc.push_back(p);
    endtask

    // Bus model, answers after 1 to 4 cycles
    always @(negedge CLK) begin
        ibus_ready = 1'b0;
        ibus_error = 1'b0;
        if (!nRST) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (mem_delay == 0) begin
                ibus_ready = 1'b1;
                ibus_error = (ibus_addr == err_addr);
                ibus_rdata = `FETCH_BUS_BIG_ENDIAN ? mem[ibus_addr[9:2]]
                                                   : swap_bytes(mem[ibus_addr[9:2]]);
                pulses++;
                mem_busy = 1'b0;
            end else begin
                mem_delay--;
            end
        end else if (ibus_req) begin
            if (ibus_addr[1:0] != 2'b00) begin
                $display("Bus request issued for misaligned address %h", ibus_addr);
                errors++;
            end
            mem_busy = 1'b1;
            mem_delay = int'(lcg_next() >> 16) % 4;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout, no accept seen after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic write_cfg(logic [1:0] a, word_t d, word_t rd);
        cfg_we = 1'b1;
        cfg_addr = a;
        cfg_wdata = d;
        @(negedge CLK);
        cfg_we = 1'b0;
        check_word("cfg_rdata", cfg_rdata, rd);
    endtask

    task automatic wait_req();
        while (!ibus_req) @(negedge CLK);
    endtask

    task automatic run_action(int r);
        case (row_kind[r])
            K_TVEC: begin
                write_cfg(`FETCH_CFG_TRAP_VEC, row_arg[r], row_arg[r]);
                trap_vec_m = row_arg[r];
            end
            K_PRED: begin
                write_cfg(`FETCH_CFG_CTRL, row_arg[r], {31'd0, row_arg[r][0]});
                pred_en_m = row_arg[r][0];
            end
            K_REDIR, K_TRAP: begin
                wait_req();
                redirect = 1'b1;
                redirect_addr = row_arg[r];
                trap = (row_kind[r] == K_TRAP);
                @(negedge CLK);
                redirect = 1'b0;
                trap = 1'b0;
                model_pc = (row_kind[r] == K_TRAP) ? trap_vec_m : row_arg[r];
            end
            K_MAL: begin
                // Stall keeps the misaligned pc in place while the fetch unit goes idle
                wait_req();
                stall = 1'b1;
                redirect = 1'b1;
                redirect_addr = row_arg[r];
                @(negedge CLK);
                redirect = 1'b0;
                while (ibus_req) @(negedge CLK);
                repeat (2) begin
                    @(negedge CLK);
                    check_bit("ibus_req", ibus_req, 1'b0);
                end
                // Second redirect leaves the misaligned pc after one accept
                stall = 1'b0;
                redirect = 1'b1;
                redirect_addr = row_arg2[r];
                @(negedge CLK);
                redirect = 1'b0;
                model_pc = row_arg[r];
            end
            default: ;
        endcase
    endtask

    task automatic hold_and_flush(bit do_flush);
        fetch_decode_t held;
        fetch_decode_t skipped;
        int p0;
        held = fd_reg;
        p0 = pulses;
        stall = 1'b1;
        // Keep stalling until the next word sits in the fetch unit
        while (pulses == p0) begin
            @(negedge CLK);
            check_fd(fd_reg, held);
        end
        repeat (2) begin
            @(negedge CLK);
            check_fd(fd_reg, held);
        end
        stall = 1'b0;
        if (do_flush) begin
            flush = 1'b1;
            @(negedge CLK);
            flush = 1'b0;
            check_fd(fd_reg, '0);
            // Held word is dropped and fetch goes on past it
            skipped = expect_fd(model_pc, 1'b0);
            model_pc = skipped.predicted_address;
        end
    endtask

    initial begin
        fetch_decode_t want;
        nRST = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        redirect = 1'b0;
        trap = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        redirect_addr = '0;
        ibus_rdata = '0;
        ibus_ready = 1'b0;
        ibus_error = 1'b0;
        seed = 32'hb37e7db5;
        errors = 0;
        cycles = 0;
        pulses = 0;
        mem_busy = 1'b0;
        mem_delay = 0;
        // Fill word is addi x1, x0 with the word's own address
        for (int i = 0; i < 256; i++) begin
            mem[i] = {2'b00, i[7:0], 2'b00, 5'd0, 3'b000, 5'd1, 7'b0010011};
        end
        put(32'h10C, enc_branch(32));
        put(32'h110, enc_jal(64));
        put(32'h150, enc_branch(-48));
        err_addr = 32'h128;

        add_row(K_NONE, 0, 0, 32'h100);
        add_row(K_NONE, 0, 0, 32'h104);
        add_row(K_NONE, 0, 0, 32'h108);
        add_row(K_NONE, 0, 0, 32'h10C);
        add_row(K_NONE, 0, 0, 32'h110);
        add_row(K_NONE, 0, 0, 32'h150);
        add_row(K_NONE, 0, 0, 32'h120);
        add_row(K_STALL, 0, 0, 32'h124);
        add_row(K_NONE, 0, 0, 32'h128);
        add_row(K_FLUSH, 0, 0, 32'h12C);
        add_row(K_NONE, 0, 0, 32'h134);
        add_row(K_TVEC, 32'h200, 0, 32'h138);
        add_row(K_REDIR, 32'h180, 0, 32'h180);
        add_row(K_NONE, 0, 0, 32'h184);
        add_row(K_TRAP, 32'h1C0, 0, 32'h200);
        add_row(K_MAL, 32'h206, 32'h150, 32'h206);
        add_row(K_NONE, 0, 0, 32'h150);
        add_row(K_PRED, 0, 0, 32'h120);
        add_row(K_REDIR, 32'h150, 0, 32'h150);
        add_row(K_NONE, 0, 0, 32'h154);
        add_row(K_REDIR, 32'h110, 0, 32'h110);
        add_row(K_NONE, 0, 0, 32'h114);
        cycle_limit = row_kind.size() * 10 + 4;

        model_pc = `FETCH_RESET_PC;
        trap_vec_m = '0;
        pred_en_m = 1'b1;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        // Nothing requested or loaded while in reset
        check_bit("ibus_req", ibus_req, 1'b0);
        check_fd(fd_reg, '0);
        nRST = 1'b1;
        @(negedge CLK);
        check_bit("ibus_req", ibus_req, 1'b1);
        check_word("ibus_addr", ibus_addr, `FETCH_RESET_PC);

        for (int r = 0; r < row_kind.size(); r++) begin
            @(negedge CLK);
            run_action(r);
            while (!fd_reg.valid) @(negedge CLK);
            if (model_pc != row_pc[r]) begin
                $display("Row %0d table pc %h disagrees with model pc %h", r, row_pc[r], model_pc);
                errors++;
            end
            want = expect_fd(model_pc, row_kind[r] == K_MAL);
            check_fd(fd_reg, want);
            model_pc = (row_kind[r] == K_MAL) ? row_arg2[r] : want.predicted_address;
            if (row_kind[r] == K_STALL || row_kind[r] == K_FLUSH) begin
                hold_and_flush(row_kind[r] == K_FLUSH);
            end
        end

        $display("Fetch run done, %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_config.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
verification/fetch_assert.sv
verification/fetch_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fetch_tb
FILELIST = tb.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the fetch testbench with Verilator"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
